// File: hdl/mips_consts.svh
// --------------------------------------------------
// MIPS widths, register count and instruction fields
// --------------------------------------------------
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_INST_SZ        32      // Instruction and data width
`define MIPS_REG_ADDR_SZ    5       // Register address width
`define MIPS_NUM_REGS       32      // Registers in the file

`define MIPS_OPC_MSB        31
`define MIPS_OPC_LSB        26
`define MIPS_RS_MSB         25
`define MIPS_RS_LSB         21
`define MIPS_RT_MSB         20
`define MIPS_RT_LSB         16
`define MIPS_RD_MSB         15
`define MIPS_RD_LSB         11
`define MIPS_FUNCT_MSB      5
`define MIPS_FUNCT_LSB      0
`define MIPS_IMM_MSB        15      // 16-bit immediate
`define MIPS_IMM_LSB        0
`define MIPS_INDEX_MSB      25      // 26-bit jump index
`define MIPS_INDEX_LSB      0

`endif

// File: hdl/mips_pkg.sv
// --------------------------------------------------
// Opcode, funct and ALU encodings plus the control
// and ID/EX bundles shared by the decode stage
// --------------------------------------------------
`include "mips_consts.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_R_TYPE = 6'h00,
        OP_J      = 6'h02,
        OP_JAL    = 6'h03,
        OP_BEQ    = 6'h04,
        OP_BNE    = 6'h05,
        OP_ADDI   = 6'h08,
        OP_SLTI   = 6'h0a,
        OP_ANDI   = 6'h0c,
        OP_ORI    = 6'h0d,
        OP_LUI    = 6'h0f,
        OP_LW     = 6'h23,
        OP_SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    // Operation handed to the execute stage
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_SLT = 4'h4,
        ALU_SLL = 4'h5,
        ALU_LUI = 4'h6
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;     // Write result back
        logic    mem_to_reg;    // Load data instead of ALU result
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;       // Immediate as second operand
        logic    reg_dst;       // rd rather than rt as target
        logic    branch;
        logic    equal;         // 1 for BEQ, 0 for BNE
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                          ctrl;
        logic [`MIPS_INST_SZ-1:0]       read_data_1;
        logic [`MIPS_INST_SZ-1:0]       read_data_2;
        logic [`MIPS_INST_SZ-1:0]       imm;            // Sign-extended
        logic [`MIPS_REG_ADDR_SZ-1:0]   rs;
        logic [`MIPS_REG_ADDR_SZ-1:0]   rt;
        logic [`MIPS_REG_ADDR_SZ-1:0]   rd;
    } id_ex_t;

endpackage

// File: hdl/register_file.sv
// --------------------------------------------------
// 32-entry register file, write-first read ports and
// a debug port, register 0 held at zero
// --------------------------------------------------
`include "mips_consts.svh"

module register_file (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_reg_write,    // Write enable from WB
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_write_reg,
    input  logic [`MIPS_INST_SZ-1:0]        i_write_data,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_read_reg_1,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_read_reg_2,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_debug_addr,
    output logic [`MIPS_INST_SZ-1:0]        o_read_data_1,
    output logic [`MIPS_INST_SZ-1:0]        o_read_data_2,
    output logic [`MIPS_INST_SZ-1:0]        o_debug_reg     // Stored value, no bypass
);

    logic [`MIPS_INST_SZ-1:0] regs [`MIPS_NUM_REGS];
    logic                     write_en;

    assign write_en = i_reg_write && (i_write_reg != '0);  // Register 0 never written

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    // A write landing this cycle wins over the stored copy
    always_comb begin
        o_read_data_1 = regs[i_read_reg_1];
        o_read_data_2 = regs[i_read_reg_2];
        if (write_en && (i_write_reg == i_read_reg_1)) begin
            o_read_data_1 = i_write_data;
        end
        if (write_en && (i_write_reg == i_read_reg_2)) begin
            o_read_data_2 = i_write_data;
        end
    end

    assign o_debug_reg = regs[i_debug_addr];

endmodule

// File: hdl/control_unit.sv
// --------------------------------------------------
// Main decoder, opcode and funct to control bundle
// --------------------------------------------------
module control_unit (
    input  mips_pkg::opcode_e   i_opcode,
    input  mips_pkg::funct_e    i_funct,   // Only looked at for R-type
    output mips_pkg::ctrl_t     o_ctrl
);

    always_comb begin
        o_ctrl = '0;                        // Unknown opcode acts as NOP
        case (i_opcode)
            mips_pkg::OP_R_TYPE: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.reg_dst   = 1'b1;
                case (i_funct)
                    mips_pkg::FN_ADD: o_ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: o_ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: o_ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  o_ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: o_ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: o_ctrl.alu_op = mips_pkg::ALU_SLL;
                    default: begin
                        // JR and unknown functs write nothing
                        o_ctrl.reg_write = 1'b0;
                        o_ctrl.reg_dst   = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_J: begin
                o_ctrl.jump = 1'b1;
            end
            mips_pkg::OP_JAL: begin
                o_ctrl.jump      = 1'b1;
                o_ctrl.reg_write = 1'b1;    // Link register write
            end
            mips_pkg::OP_BEQ: begin
                o_ctrl.branch = 1'b1;
                o_ctrl.equal  = 1'b1;
                o_ctrl.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_BNE: begin
                o_ctrl.branch = 1'b1;
                o_ctrl.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_ADDI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_SLTI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = mips_pkg::ALU_SLT;
            end
            mips_pkg::OP_ANDI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = mips_pkg::ALU_AND;
            end
            mips_pkg::OP_ORI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = mips_pkg::ALU_OR;
            end
            mips_pkg::OP_LUI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = mips_pkg::ALU_LUI;
            end
            mips_pkg::OP_LW: begin
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.alu_src    = 1'b1;   // Base plus offset
            end
            mips_pkg::OP_SW: begin
                o_ctrl.mem_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
            end
            default: o_ctrl = '0;
        endcase
    end

endmodule

// File: hdl/branch_unit.sv
// --------------------------------------------------
// Early branch resolution with M-stage forwarding
// and branch target adder
// --------------------------------------------------
`include "mips_consts.svh"

module branch_unit (
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_rs,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_rt,
    input  logic [`MIPS_INST_SZ-1:0]        i_read_data_1,
    input  logic [`MIPS_INST_SZ-1:0]        i_read_data_2,
    input  logic                            i_reg_write_M,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_write_reg_M,
    input  logic [`MIPS_INST_SZ-1:0]        i_alu_result_M,
    input  mips_pkg::ctrl_t                 i_ctrl,
    input  logic [`MIPS_INST_SZ-1:0]        i_imm,          // Already sign-extended
    input  logic [`MIPS_INST_SZ-1:0]        i_npc,
    input  logic                            i_valid,
    output logic                            o_pc_src,
    output logic [`MIPS_INST_SZ-1:0]        o_branch_addr
);

    logic                       m_writes;
    logic                       fwd_a;
    logic                       fwd_b;
    logic [`MIPS_INST_SZ-1:0]   operand_a;
    logic [`MIPS_INST_SZ-1:0]   operand_b;
    logic                       operands_equal;
    logic [`MIPS_INST_SZ-1:0]   shifted_imm;

    // M stage result is only usable when it targets a real register
    assign m_writes = i_reg_write_M && (i_write_reg_M != '0);
    assign fwd_a    = m_writes && (i_write_reg_M == i_rs);
    assign fwd_b    = m_writes && (i_write_reg_M == i_rt);

    assign operand_a = fwd_a ? i_alu_result_M : i_read_data_1;
    assign operand_b = fwd_b ? i_alu_result_M : i_read_data_2;

    assign operands_equal = (operand_a == operand_b);

    // BEQ takes on equal, BNE on not equal
    assign o_pc_src = i_valid && i_ctrl.branch && (operands_equal == i_ctrl.equal);

    assign shifted_imm   = i_imm << 2;                  // Word offset to bytes
    assign o_branch_addr = i_npc + shifted_imm;         // Wraps modulo 2^32

endmodule

// File: hdl/instruction_decode.sv
// --------------------------------------------------
// ID stage: field split, register read, control
// decode, branch resolve and jump target
// --------------------------------------------------
`include "mips_consts.svh"

module instruction_decode (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_valid_F,          // Fetch strobe
    input  logic [`MIPS_INST_SZ-1:0]        i_instruction_F,
    input  logic [`MIPS_INST_SZ-1:0]        i_npc_F,
    input  logic                            i_reg_write_W,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_write_reg_W,
    input  logic [`MIPS_INST_SZ-1:0]        i_write_data_W,
    input  logic                            i_reg_write_M,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_write_reg_M,
    input  logic [`MIPS_INST_SZ-1:0]        i_alu_result_M,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_debug_addr,
    output mips_pkg::id_ex_t                o_id_ex,
    output logic                            o_id_ex_valid_D,
    output logic                            o_pc_src,
    output logic [`MIPS_INST_SZ-1:0]        o_branch_addr,
    output logic                            o_jump,
    output logic [`MIPS_INST_SZ-1:0]        o_jump_addr,
    output logic [`MIPS_INST_SZ-1:0]        o_debug_reg
);

    mips_pkg::opcode_e                  opcode;
    mips_pkg::funct_e                   funct;
    mips_pkg::ctrl_t                    ctrl;
    logic [`MIPS_REG_ADDR_SZ-1:0]       rs;
    logic [`MIPS_REG_ADDR_SZ-1:0]       rt;
    logic [`MIPS_REG_ADDR_SZ-1:0]       rd;
    logic [`MIPS_INST_SZ-1:0]           imm_ext;
    logic [`MIPS_INST_SZ-1:0]           read_data_1;
    logic [`MIPS_INST_SZ-1:0]           read_data_2;

    assign opcode = mips_pkg::opcode_e'(i_instruction_F[`MIPS_OPC_MSB:`MIPS_OPC_LSB]);
    assign funct  = mips_pkg::funct_e'(i_instruction_F[`MIPS_FUNCT_MSB:`MIPS_FUNCT_LSB]);
    assign rs     = i_instruction_F[`MIPS_RS_MSB:`MIPS_RS_LSB];
    assign rt     = i_instruction_F[`MIPS_RT_MSB:`MIPS_RT_LSB];
    assign rd     = i_instruction_F[`MIPS_RD_MSB:`MIPS_RD_LSB];

    // Sign bit of the 16-bit immediate fills the upper half
    assign imm_ext = {{(`MIPS_INST_SZ-16){i_instruction_F[`MIPS_IMM_MSB]}},
                      i_instruction_F[`MIPS_IMM_MSB:`MIPS_IMM_LSB]};

    register_file u_register_file (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_reg_write    (i_reg_write_W),
        .i_write_reg    (i_write_reg_W),
        .i_write_data   (i_write_data_W),
        .i_read_reg_1   (rs),
        .i_read_reg_2   (rt),
        .i_debug_addr   (i_debug_addr),
        .o_read_data_1  (read_data_1),
        .o_read_data_2  (read_data_2),
        .o_debug_reg    (o_debug_reg)
    );

    control_unit u_control_unit (
        .i_opcode   (opcode),
        .i_funct    (funct),
        .o_ctrl     (ctrl)
    );

    branch_unit u_branch_unit (
        .i_rs           (rs),
        .i_rt           (rt),
        .i_read_data_1  (read_data_1),
        .i_read_data_2  (read_data_2),
        .i_reg_write_M  (i_reg_write_M),
        .i_write_reg_M  (i_write_reg_M),
        .i_alu_result_M (i_alu_result_M),
        .i_ctrl         (ctrl),
        .i_imm          (imm_ext),
        .i_npc          (i_npc_F),
        .i_valid        (i_valid_F),
        .o_pc_src       (o_pc_src),
        .o_branch_addr  (o_branch_addr)
    );

    // Region bits of the next PC, then the word index
    assign o_jump_addr = {i_npc_F[`MIPS_INST_SZ-1:`MIPS_INST_SZ-4],
                          i_instruction_F[`MIPS_INDEX_MSB:`MIPS_INDEX_LSB], 2'b00};
    assign o_jump      = i_valid_F && ctrl.jump;

    always_comb begin
        o_id_ex.ctrl        = ctrl;
        o_id_ex.read_data_1 = read_data_1;      // Bypassed, not M-forwarded
        o_id_ex.read_data_2 = read_data_2;
        o_id_ex.imm         = imm_ext;
        o_id_ex.rs          = rs;
        o_id_ex.rt          = rt;
        o_id_ex.rd          = rd;
    end

    assign o_id_ex_valid_D = i_valid_F;

endmodule

// File: hdl/id_ex_register.sv
// --------------------------------------------------
// ID/EX pipeline register with valid bit
// --------------------------------------------------
module id_ex_register (
    input  logic                i_clk,
    input  logic                i_reset,
    input  mips_pkg::id_ex_t    i_id_ex,
    input  logic                i_valid,    // Decode strobe
    output mips_pkg::id_ex_t    o_id_ex,
    output logic                o_valid
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_id_ex <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;             // High for one cycle per strobe
            if (i_valid) begin
                o_id_ex <= i_id_ex;         // Holds between strobes
            end
        end
    end

endmodule

// File: hdl/mips_decode_top.sv
// --------------------------------------------------
// Decode subsystem top, ID stage plus ID/EX register
// --------------------------------------------------
`include "mips_consts.svh"

module mips_decode_top (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_valid_F,
    input  logic [`MIPS_INST_SZ-1:0]        i_instruction_F,
    input  logic [`MIPS_INST_SZ-1:0]        i_npc_F,
    input  logic                            i_reg_write_W,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_write_reg_W,
    input  logic [`MIPS_INST_SZ-1:0]        i_write_data_W,
    input  logic                            i_reg_write_M,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_write_reg_M,
    input  logic [`MIPS_INST_SZ-1:0]        i_alu_result_M,
    input  logic [`MIPS_REG_ADDR_SZ-1:0]    i_debug_addr,
    output mips_pkg::id_ex_t                o_id_ex,
    output logic                            o_id_ex_valid,
    output logic                            o_pc_src,
    output logic [`MIPS_INST_SZ-1:0]        o_branch_addr,
    output logic                            o_jump,
    output logic [`MIPS_INST_SZ-1:0]        o_jump_addr,
    output logic [`MIPS_INST_SZ-1:0]        o_debug_reg
);

    mips_pkg::id_ex_t   id_ex_D;
    logic               id_ex_valid_D;

    instruction_decode u_instruction_decode (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_valid_F       (i_valid_F),
        .i_instruction_F (i_instruction_F),
        .i_npc_F         (i_npc_F),
        .i_reg_write_W   (i_reg_write_W),
        .i_write_reg_W   (i_write_reg_W),
        .i_write_data_W  (i_write_data_W),
        .i_reg_write_M   (i_reg_write_M),
        .i_write_reg_M   (i_write_reg_M),
        .i_alu_result_M  (i_alu_result_M),
        .i_debug_addr    (i_debug_addr),
        .o_id_ex         (id_ex_D),
        .o_id_ex_valid_D (id_ex_valid_D),
        .o_pc_src        (o_pc_src),
        .o_branch_addr   (o_branch_addr),
        .o_jump          (o_jump),
        .o_jump_addr     (o_jump_addr),
        .o_debug_reg     (o_debug_reg)
    );

    id_ex_register u_id_ex_register (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_id_ex    (id_ex_D),
        .i_valid    (id_ex_valid_D),
        .o_id_ex    (o_id_ex),
        .o_valid    (o_id_ex_valid)
    );

endmodule

// File: test/tb_mips_decode.sv
// --------------------------------------------------
// Random testbench for the decode subsystem, checked
// against a register file and decode model
// --------------------------------------------------
`include "mips_consts.svh"

module tb_mips_decode;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 2;
    localparam int NUM_ITEMS    = 400;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + `MIPS_NUM_REGS + NUM_ITEMS + 1 + 64;

    logic                           i_clk = 1'b0;
    logic                           i_reset;
    logic                           i_valid_F;
    logic [`MIPS_INST_SZ-1:0]       i_instruction_F;
    logic [`MIPS_INST_SZ-1:0]       i_npc_F;
    logic                           i_reg_write_W;
    logic [`MIPS_REG_ADDR_SZ-1:0]   i_write_reg_W;
    logic [`MIPS_INST_SZ-1:0]       i_write_data_W;
    logic                           i_reg_write_M;
    logic [`MIPS_REG_ADDR_SZ-1:0]   i_write_reg_M;
    logic [`MIPS_INST_SZ-1:0]       i_alu_result_M;
    logic [`MIPS_REG_ADDR_SZ-1:0]   i_debug_addr;
    mips_pkg::id_ex_t               o_id_ex;
    logic                           o_id_ex_valid;
    logic                           o_pc_src;
    logic [`MIPS_INST_SZ-1:0]       o_branch_addr;
    logic                           o_jump;
    logic [`MIPS_INST_SZ-1:0]       o_jump_addr;
    logic [`MIPS_INST_SZ-1:0]       o_debug_reg;

    logic [31:0]                    seed = 32'h2bb6;
    logic [`MIPS_INST_SZ-1:0]       model_regs [`MIPS_NUM_REGS];
    mips_pkg::id_ex_t               exp_id_ex;          // What ID/EX should hold now
    logic                           exp_valid;
    logic [`MIPS_REG_ADDR_SZ-1:0]   last_wb_reg;        // Debug port looks here next
    int                             errors = 0;
    int                             checks = 0;
    int                             cycle_count = 0;

    logic [5:0] opcode_list [12] = '{
        mips_pkg::OP_R_TYPE, mips_pkg::OP_J, mips_pkg::OP_JAL, mips_pkg::OP_BEQ,
        mips_pkg::OP_BNE, mips_pkg::OP_ADDI, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI,
        mips_pkg::OP_ORI, mips_pkg::OP_LUI, mips_pkg::OP_LW, mips_pkg::OP_SW
    };
    logic [5:0] funct_list [7] = '{
        mips_pkg::FN_ADD, mips_pkg::FN_SUB, mips_pkg::FN_AND, mips_pkg::FN_OR,
        mips_pkg::FN_SLT, mips_pkg::FN_SLL, mips_pkg::FN_JR
    };

    mips_decode_top u_mips_decode_top (.*);

    always #4 i_clk = ~i_clk;                           // 8 ns period

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Upper LCG bits are the better mixed ones
    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return r[31:16] % n;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Register read as the ID stage sees it, same-cycle write-back first
    function automatic logic [31:0] bypass_read(input logic [4:0] addr);
        if (i_reg_write_W && (i_write_reg_W != '0) && (i_write_reg_W == addr)) begin
            return i_write_data_W;
        end
        return model_regs[addr];
    endfunction

    function automatic mips_pkg::ctrl_t expected_ctrl(input logic [5:0] op,
                                                      input logic [5:0] fn);
        mips_pkg::ctrl_t c;
        logic            r_alu;
        logic            imm_alu;
        c     = '0;
        r_alu = 1'b0;
        case (op)
            mips_pkg::OP_R_TYPE: begin
                r_alu = 1'b1;
                case (fn)
                    mips_pkg::FN_ADD: c.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: c.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: c.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  c.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: c.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: c.alu_op = mips_pkg::ALU_SLL;
                    default:          r_alu    = 1'b0;  // JR writes nothing
                endcase
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: c.alu_op = mips_pkg::ALU_SUB;
            mips_pkg::OP_SLTI: c.alu_op = mips_pkg::ALU_SLT;
            mips_pkg::OP_ANDI: c.alu_op = mips_pkg::ALU_AND;
            mips_pkg::OP_ORI:  c.alu_op = mips_pkg::ALU_OR;
            mips_pkg::OP_LUI:  c.alu_op = mips_pkg::ALU_LUI;
            default:           c.alu_op = mips_pkg::ALU_ADD;
        endcase
        imm_alu      = (op == mips_pkg::OP_ADDI) || (op == mips_pkg::OP_SLTI) ||
                       (op == mips_pkg::OP_ANDI) || (op == mips_pkg::OP_ORI) ||
                       (op == mips_pkg::OP_LUI);
        c.reg_write  = r_alu || imm_alu || (op == mips_pkg::OP_JAL) || (op == mips_pkg::OP_LW);
        c.reg_dst    = r_alu;
        c.mem_read   = (op == mips_pkg::OP_LW);
        c.mem_to_reg = (op == mips_pkg::OP_LW);
        c.mem_write  = (op == mips_pkg::OP_SW);
        c.alu_src    = imm_alu || (op == mips_pkg::OP_LW) || (op == mips_pkg::OP_SW);
        c.branch     = (op == mips_pkg::OP_BEQ) || (op == mips_pkg::OP_BNE);
        c.equal      = (op == mips_pkg::OP_BEQ);
        c.jump       = (op == mips_pkg::OP_J) || (op == mips_pkg::OP_JAL);
        return c;
    endfunction

    task automatic drive_item();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  wb_reg;
        logic [31:0] r;
        logic [31:0] instr;
        int unsigned m_sel;
        @(posedge i_clk);
        rs     = 5'(pick(32));
        rt     = (pick(4) == 0) ? rs : 5'(pick(32));   // Equal operands now and then
        r      = next_rand();
        instr  = {opcode_list[pick(12)], rs, rt, r[31:16]};
        if (instr[`MIPS_OPC_MSB:`MIPS_OPC_LSB] == mips_pkg::OP_R_TYPE) begin
            instr[`MIPS_FUNCT_MSB:`MIPS_FUNCT_LSB] = funct_list[pick(7)];
        end
        wb_reg = (pick(4) == 0) ? rs : 5'(pick(32));
        m_sel  = pick(4);
        i_valid_F       <= (pick(4) != 0);
        i_instruction_F <= instr;
        i_npc_F         <= next_rand() & 32'hffff_fffc;
        i_reg_write_W   <= (pick(2) == 1);
        i_write_reg_W   <= wb_reg;
        i_write_data_W  <= next_rand();
        i_reg_write_M   <= (pick(2) == 1);
        i_write_reg_M   <= (m_sel == 0) ? rs : ((m_sel == 1) ? rt : 5'(pick(32)));
        i_alu_result_M  <= (pick(2) == 0) ? model_regs[rt] : next_rand();
        i_debug_addr    <= (pick(2) == 0) ? last_wb_reg : 5'(pick(32));
        last_wb_reg = wb_reg;
    endtask

    // Compares all outputs mid-cycle, then advances the model by one clock
    task automatic check_cycle();
        mips_pkg::ctrl_t c;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [31:0]     imm;
        logic [31:0]     a;
        logic [31:0]     b;
        logic            m_ok;
        logic            eq;
        logic [31:0]     target;                        // Branch target, wraps at 32 bits
        @(negedge i_clk);
        check_value("id_ex_valid", exp_valid, o_id_ex_valid);
        check_value("id_ex_bundle", exp_id_ex, o_id_ex);
        check_value("debug_reg", model_regs[i_debug_addr], o_debug_reg);
        rs   = i_instruction_F[`MIPS_RS_MSB:`MIPS_RS_LSB];
        rt   = i_instruction_F[`MIPS_RT_MSB:`MIPS_RT_LSB];
        imm  = {{16{i_instruction_F[15]}}, i_instruction_F[15:0]};
        c    = expected_ctrl(i_instruction_F[31:26], i_instruction_F[5:0]);
        a    = bypass_read(rs);
        b    = bypass_read(rt);
        m_ok = i_reg_write_M && (i_write_reg_M != '0);
        eq   = (((m_ok && (i_write_reg_M == rs)) ? i_alu_result_M : a) ==
                ((m_ok && (i_write_reg_M == rt)) ? i_alu_result_M : b));
        target = i_npc_F + (imm << 2);
        check_value("pc_src", i_valid_F && c.branch && (eq == c.equal), o_pc_src);
        check_value("branch_addr", target, o_branch_addr);
        check_value("jump", i_valid_F && c.jump, o_jump);
        check_value("jump_addr", {i_npc_F[31:28], i_instruction_F[25:0], 2'b00}, o_jump_addr);
        if (i_valid_F) begin
            exp_id_ex = {c, a, b, imm, rs, rt, i_instruction_F[`MIPS_RD_MSB:`MIPS_RD_LSB]};
        end
        exp_valid = i_valid_F;
        if (i_reg_write_W && (i_write_reg_W != '0)) begin
            model_regs[i_write_reg_W] = i_write_data_W;     // Lands at the next edge
        end
    endtask

    initial begin
        i_reset         = 1'b1;
        i_valid_F       = 1'b0;
        i_instruction_F = '0;
        i_npc_F         = '0;
        i_reg_write_W   = 1'b0;
        i_write_reg_W   = '0;
        i_write_data_W  = '0;
        i_reg_write_M   = 1'b0;
        i_write_reg_M   = '0;
        i_alu_result_M  = '0;
        i_debug_addr    = '0;
        exp_id_ex       = '0;
        exp_valid       = 1'b0;
        last_wb_reg     = '0;
        for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;

        // Every register must read zero straight after reset
        for (int a = 0; a < `MIPS_NUM_REGS; a++) begin
            @(posedge i_clk);
            i_debug_addr <= 5'(a);
            check_cycle();
            check_value("reset_debug_zero", '0, o_debug_reg);
        end

        repeat (NUM_ITEMS) begin
            drive_item();
            check_cycle();
        end
        @(posedge i_clk);
        i_valid_F <= 1'b0;                              // Drain the last item
        check_cycle();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/register_file.sv
hdl/control_unit.sv
hdl/branch_unit.sv
hdl/instruction_decode.sv
hdl/id_ex_register.sv
hdl/mips_decode_top.sv
test/tb_mips_decode.sv

// File: Bender.yml
package:
  name: mips_decode

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_pkg.sv
      - hdl/register_file.sv
      - hdl/control_unit.sv
      - hdl/branch_unit.sv
      - hdl/instruction_decode.sv
      - hdl/id_ex_register.sv
      - hdl/mips_decode_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_mips_decode.sv
